//--- sources.f
+incdir+include
logic/probe_pkg.sv
logic/capture_buffer.sv
logic/pin_sampler.sv
logic/probe_regs.sv
logic/probe_top.sv
sim/probe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the probe testbench with Verilator and run it, the exit status is the result
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal --top-module probe_tb \
		-f sources.f -o probe_sim &&
	./obj_dir/probe_sim ||
	exit 1

//--- include/probe_tb_tasks.svh
`ifndef PROBE_TB_TASKS_SVH
`define PROBE_TB_TASKS_SVH

// one four-phase access
// ack and rdata are read right after the edge, before any DUT register updates
task automatic host_access(input logic [7:0] offset, input logic is_write,
		input logic [7:0] wbyte, output logic [7:0] data);
	@(posedge mai);
	host_in <= '{addr: offset, wr: is_write, wdata: wbyte};
	req     <= 1'b1;
	do begin
		@(posedge mai);
	end while (ack !== 1'b1);
	data = rdata;
	req <= 1'b0;
	do begin
		@(posedge mai);
	end while (ack !== 1'b0);
endtask

task automatic host_write(input logic [7:0] offset, input logic [7:0] wbyte);
	logic [7:0] ignored;
	host_access(offset, 1'b1, wbyte, ignored);
endtask

task automatic host_read(input logic [7:0] offset, output logic [7:0] data);
	host_access(offset, 1'b0, 8'h00, data);
endtask

// level a channel sees, selects past the last pin give 0
function automatic logic pin_level(input logic [PROBE_WIDTH-1:0] pins, input logic [7:0] sel);
	if (int'(sel) < PROBE_WIDTH) begin
		return pins[sel[PIN_IDX_W-1:0]];
	end
	return 1'b0;
endfunction

function automatic logic [7:0] level_byte(input logic level);
	return level ? 8'hFF : 8'h00;
endfunction

// channel 0 fills the first SAMPLE_BYTES reads, channel 1 the rest
function automatic logic [7:0] expected_byte(input int index, input logic [7:0] ch0_sel,
		input logic [7:0] ch1_sel, input logic [PROBE_WIDTH-1:0] pins);
	if (index < SAMPLE_BYTES) begin
		return level_byte(pin_level(pins, ch0_sel));
	end
	return level_byte(pin_level(pins, ch1_sel));
endfunction

// random pin at the wanted level, the pattern holds at least one
function automatic logic [7:0] find_pin(input logic [PROBE_WIDTH-1:0] pins, input logic level);
	int start;
	int pin;
	int i;
	start = $urandom_range(0, PROBE_WIDTH - 1);
	for (i = 0; i < PROBE_WIDTH; i++) begin
		pin = (start + i) % PROBE_WIDTH;
		if (pins[pin] == level) begin
			return 8'(pin);
		end
	end
	return 8'h00;
endfunction

`endif

//--- sim/probe_tb.sv
`timescale 1ns/1ns
`default_nettype none

module probe_tb;
	import probe_pkg::*;

	localparam int PROBE_WIDTH  = 16;
	localparam int SAMPLE_BYTES = 128;
	localparam int PIN_IDX_W    = $clog2(PROBE_WIDTH);
	localparam int DIV_MAX      = 3;
	localparam int CAPTURES     = 3;
	// twice the nominal capture length each plus room for host traffic
	localparam int WATCHDOG_CYCLES =
		CAPTURES * 2 * 8 * SAMPLE_BYTES * (DIV_MAX + 1) + 20000;

	logic                   mai;
	logic                   voltage_idx_reset;
	logic                   req;
	host_req_t              host_in;
	logic                   ack;
	logic [7:0]             rdata;
	logic [PROBE_WIDTH-1:0] probe_pins;

	logic [7:0]             cfg_regs [5];
	logic [7:0]             written [5];
	logic [PROBE_WIDTH-1:0] pattern;
	logic [7:0]             sel0;
	logic [7:0]             sel1;
	logic [7:0]             value;

	probe_top #(
		.PROBE_WIDTH  (PROBE_WIDTH),
		.SAMPLE_BYTES (SAMPLE_BYTES)
	) DUT (
		.mai               (mai),
		.voltage_idx_reset (voltage_idx_reset),
		.req               (req),
		.host_in           (host_in),
		.ack               (ack),
		.rdata             (rdata),
		.probe_pins        (probe_pins)
	);

	`include "probe_tb_tasks.svh"

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("Error: rdata 0x%02h, expected 0x%02h (%s)", got, exp, what);
			stop_run();
		end
	endtask

	task automatic wait_ready();
		logic [7:0] status;
		status = 8'h00;
		while (status[0] !== 1'b1) begin
			host_read(REG_READY, status);
			check_byte("REG_READY upper bits", status & 8'hFE, 8'h00);
		end
	endtask

	// wait for the capture and read both channels once through
	task automatic capture_pass();
		logic [7:0] data;
		int         i;
		wait_ready();
		host_write(REG_IDX_RESET, 8'h00);
		for (i = 0; i < 2 * SAMPLE_BYTES; i++) begin
			host_read(REG_DATA, data);
			check_byte($sformatf("REG_DATA read %0d", i), data,
				expected_byte(i, sel0, sel1, pattern));
		end
	endtask

	initial begin
		mai = 1'b0;
		forever #5 mai = ~mai;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge mai);
		$display("watchdog expired before the test sequence finished");
		stop_run();
	end

	// req first sampled high at n means ack first sampled high at n+3
	ack_rise: assert property (@(posedge mai) disable iff (voltage_idx_reset)
		$rose(ack) == ($past(req, 3) && !$past(req, 4)))
		else begin
			$display("ack did not rise exactly 2 cycles after req was seen high");
			stop_run();
		end

	// req first sampled low at n means ack first sampled low at n+2
	ack_fall: assert property (@(posedge mai) disable iff (voltage_idx_reset)
		$fell(ack) == ($past(req, 3) && !$past(req, 2)))
		else begin
			$display("ack did not fall 1 cycle after req was seen low");
			stop_run();
		end

	initial begin
		int i;
		void'($urandom(12510));
		voltage_idx_reset = 1'b1;
		req               = 1'b0;
		host_in           = '0;
		probe_pins        = '0;
		cfg_regs = '{REG_PIN_SEL0, REG_PIN_SEL1, REG_DIV0, REG_DIV1, REG_DIV2};
		repeat (4) @(posedge mai);
		voltage_idx_reset <= 1'b0;

		// state after reset
		assert (ack === 1'b0) else begin
			$display("Error: ack 0x%0h after reset, expected 0x0", ack);
			stop_run();
		end
		host_read(REG_READY, value);
		check_byte("REG_READY after reset", value, 8'h00);
		for (i = 0; i < 5; i++) begin
			host_read(cfg_regs[i], value);
			check_byte($sformatf("offset 0x%02h after reset", cfg_regs[i]), value,
				(cfg_regs[i] == REG_PIN_SEL1) ? 8'h02 : 8'h00);
		end
		host_read(8'h07, value);
		check_byte("unmapped offset 0x07", value, 8'h00);

		// register readback with random values
		for (i = 0; i < 5; i++) begin
			written[i] = 8'($urandom);
			host_write(cfg_regs[i], written[i]);
		end
		for (i = 0; i < 5; i++) begin
			host_read(cfg_regs[i], value);
			check_byte($sformatf("readback of offset 0x%02h", cfg_regs[i]), value, written[i]);
		end

		// static capture with one high pin and one low pin
		pattern = PROBE_WIDTH'($urandom);
		if ((&pattern) || !(|pattern)) begin
			pattern[0] = ~pattern[0];
		end
		sel0 = find_pin(pattern, 1'b1);
		sel1 = find_pin(pattern, 1'b0);
		probe_pins <= pattern;
		host_write(REG_DIV0, 8'($urandom_range(0, DIV_MAX)));
		host_write(REG_DIV1, 8'h00);
		host_write(REG_DIV2, 8'h00);
		host_write(REG_PIN_SEL0, sel0);
		host_write(REG_PIN_SEL1, sel1);
		host_write(REG_ARM, 8'h01);
		capture_pass();

		// select past the last pin reads as 0
		sel0 = 8'($urandom_range(PROBE_WIDTH, 255));
		host_write(REG_PIN_SEL0, sel0);
		host_write(REG_ARM, 8'h01);
		capture_pass();

		// arming clears ready and the read index wraps after 256 reads
		sel0 = find_pin(pattern, 1'b1);
		host_write(REG_PIN_SEL0, sel0);
		host_write(REG_ARM, 8'h01);
		host_read(REG_READY, value);
		check_byte("REG_READY right after arm", value, 8'h00);
		capture_pass();
		host_read(REG_DATA, value);
		check_byte("REG_DATA read 257 after wrap", value,
			expected_byte(0, sel0, sel1, pattern));

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/probe_top.sv
`timescale 1ns/1ns
`default_nettype none

module probe_top #(
	parameter int PROBE_WIDTH  = 16,
	parameter int SAMPLE_BYTES = 128
) (
	input  logic                         mai,
	input  logic                         voltage_idx_reset,
	input  logic                         req,
	input  probe_pkg::host_req_t         host_in,
	output logic                         ack,
	output logic [probe_pkg::DATA_W-1:0] rdata,
	input  logic [PROBE_WIDTH-1:0]       probe_pins
);
	import probe_pkg::*;

	probe_cfg_t        cfg;
	logic              arm;
	logic              ready;
	cap_wr_t           cap_wr;
	logic [7:0]        rd_index;
	logic [DATA_W-1:0] rd_byte;

	// host registers and readback
	probe_regs u_regs (
		.mai               (mai),
		.voltage_idx_reset (voltage_idx_reset),
		.req               (req),
		.host_in           (host_in),
		.ack               (ack),
		.rdata             (rdata),
		.cfg               (cfg),
		.arm               (arm),
		.ready             (ready),
		.rd_index          (rd_index),
		.rd_byte           (rd_byte)
	);

	pin_sampler #(
		.PROBE_WIDTH  (PROBE_WIDTH),
		.SAMPLE_BYTES (SAMPLE_BYTES)
	) u_sampler (
		.mai               (mai),
		.voltage_idx_reset (voltage_idx_reset),
		.cfg               (cfg),
		.arm               (arm),
		.probe_pins        (probe_pins),
		.wr                (cap_wr),
		.ready             (ready)
	);

	// written by the sampler, read through the data register
	capture_buffer #(
		.SAMPLE_BYTES (SAMPLE_BYTES)
	) u_buffer (
		.mai      (mai),
		.wr       (cap_wr),
		.rd_index (rd_index),
		.rd_byte  (rd_byte)
	);

endmodule

`default_nettype wire

//--- logic/probe_regs.sv
`timescale 1ns/1ns
`default_nettype none

module probe_regs (
	input  logic                         mai,
	input  logic                         voltage_idx_reset,
	input  logic                         req,
	input  probe_pkg::host_req_t         host_in,
	output logic                         ack,
	output logic [probe_pkg::DATA_W-1:0] rdata,
	output probe_pkg::probe_cfg_t        cfg,
	output logic                         arm,
	input  logic                         ready,
	output logic [7:0]                   rd_index,
	input  logic [probe_pkg::DATA_W-1:0] rd_byte
);
	import probe_pkg::*;

	// four-phase handshake, two wait states before ack
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT1,
		ST_WAIT2,
		ST_ACK,
		ST_DROP
	} hs_state_t;

	hs_state_t         state;
	logic              access;
	logic              is_wr;
	logic              is_rd;
	logic [DATA_W-1:0] rd_mux;

	// access fires on the edge where ack rises
	assign access = (state == ST_WAIT2);
	assign is_wr  = access && host_in.wr;
	assign is_rd  = access && !host_in.wr;
	assign ack    = (state == ST_ACK) || (state == ST_DROP);
	assign arm    = is_wr && (host_in.addr == REG_ARM);

	always_ff @(posedge mai) begin
		if (voltage_idx_reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:  if (req) state <= ST_WAIT1;
				ST_WAIT1: state <= ST_WAIT2;
				ST_WAIT2: state <= ST_ACK;
				ST_ACK:   if (!req) state <= ST_DROP;
				ST_DROP:  state <= ST_IDLE;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	// pin selects and divider bytes
	always_ff @(posedge mai) begin
		if (voltage_idx_reset) begin
			cfg.pin_sel0 <= '0;
			cfg.pin_sel1 <= SEL_W'(2);
			cfg.divider  <= '0;
		end else if (is_wr) begin
			case (host_in.addr)
				REG_PIN_SEL0: cfg.pin_sel0 <= host_in.wdata;
				REG_PIN_SEL1: cfg.pin_sel1 <= host_in.wdata;
				REG_DIV0:     cfg.divider[7:0] <= host_in.wdata;
				REG_DIV1:     cfg.divider[15:8] <= host_in.wdata;
				REG_DIV2:     cfg.divider[23:16] <= host_in.wdata;
				default:      ;
			endcase
		end
	end

	// read index, auto-increments on each data read and wraps at 255
	always_ff @(posedge mai) begin
		if (voltage_idx_reset) begin
			rd_index <= '0;
		end else if (is_wr && (host_in.addr == REG_IDX_RESET)) begin
			rd_index <= '0;
		end else if (is_rd && (host_in.addr == REG_DATA)) begin
			rd_index <= rd_index + 8'd1;
		end
	end

	always_comb begin
		case (host_in.addr)
			REG_PIN_SEL0: rd_mux = cfg.pin_sel0;
			REG_PIN_SEL1: rd_mux = cfg.pin_sel1;
			REG_DIV0:     rd_mux = cfg.divider[7:0];
			REG_DIV1:     rd_mux = cfg.divider[15:8];
			REG_DIV2:     rd_mux = cfg.divider[23:16];
			REG_READY:    rd_mux = {{(DATA_W - 1){1'b0}}, ready};
			// buffer output already reflects the current index
			REG_DATA:     rd_mux = rd_byte;
			default:      rd_mux = '0;
		endcase
	end

	always_ff @(posedge mai) begin
		if (voltage_idx_reset) begin
			rdata <= '0;
		end else if (is_rd) begin
			rdata <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- logic/pin_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module pin_sampler #(
	parameter int PROBE_WIDTH  = 16,
	parameter int SAMPLE_BYTES = 128
) (
	input  logic                  mai,
	input  logic                  voltage_idx_reset,
	input  probe_pkg::probe_cfg_t cfg,
	input  logic                  arm,
	input  logic [PROBE_WIDTH-1:0] probe_pins,
	output probe_pkg::cap_wr_t    wr,
	output logic                  ready
);
	import probe_pkg::*;

	localparam int         PIN_SPACE = 2 ** SEL_W;
	localparam logic [7:0] LAST_BYTE = 8'(SAMPLE_BYTES - 1);

	// pins beyond PROBE_WIDTH read as 0
	logic [PIN_SPACE-1:0] pins_ext;
	logic                 pin0;
	logic                 pin1;

	logic             capturing;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       byte_addr;
	logic             tick;
	logic             store;

	logic [7:0] shift0;
	logic [7:0] shift1;
	logic       wr_we;
	logic [7:0] wr_addr;
	logic [7:0] wr_byte0;
	logic [7:0] wr_byte1;

	assign pins_ext = PIN_SPACE'(probe_pins);
	assign pin0     = pins_ext[cfg.pin_sel0];
	assign pin1     = pins_ext[cfg.pin_sel1];

	// >= keeps the tick alive if the divider shrinks mid-capture
	assign tick  = capturing && (div_cnt >= cfg.divider);
	assign store = tick && (bit_cnt == 3'd7);

	always_ff @(posedge mai) begin
		if (voltage_idx_reset) begin
			capturing <= 1'b0;
			ready     <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			byte_addr <= '0;
			wr_we     <= 1'b0;
		end else if (arm) begin
			// restart from scratch, even mid-capture
			capturing <= 1'b1;
			ready     <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			byte_addr <= '0;
			wr_we     <= 1'b0;
		end else begin
			wr_we <= store;
			if (capturing) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
			end
			if (tick) begin
				bit_cnt <= bit_cnt + 3'd1;
			end
			if (store) begin
				byte_addr <= byte_addr + 8'd1;
				if (byte_addr == LAST_BYTE) begin
					capturing <= 1'b0;
					ready     <= 1'b1;
				end
			end
		end
	end

	// samples enter at the lsb, so the first one ends up in bit 7
	always_ff @(posedge mai) begin
		if (tick) begin
			shift0 <= {shift0[6:0], pin0};
			shift1 <= {shift1[6:0], pin1};
		end
		if (store) begin
			wr_addr  <= byte_addr;
			wr_byte0 <= {shift0[6:0], pin0};
			wr_byte1 <= {shift1[6:0], pin1};
		end
	end

	assign wr = '{we: wr_we, addr: wr_addr, byte0: wr_byte0, byte1: wr_byte1};

endmodule

`default_nettype wire

//--- logic/capture_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module capture_buffer #(
	parameter int SAMPLE_BYTES = 128
) (
	input  logic                         mai,
	input  probe_pkg::cap_wr_t           wr,
	input  logic [7:0]                   rd_index,
	output logic [probe_pkg::DATA_W-1:0] rd_byte
);
	import probe_pkg::*;

	localparam int IDX_W = $clog2(SAMPLE_BYTES);

	// one memory per pin channel
	logic [DATA_W-1:0] mem0 [SAMPLE_BYTES];
	logic [DATA_W-1:0] mem1 [SAMPLE_BYTES];

	logic [IDX_W-1:0] wr_entry;
	logic [IDX_W-1:0] rd_entry;
	logic             rd_chan;

	assign wr_entry = wr.addr[IDX_W-1:0];
	assign rd_entry = rd_index[IDX_W-1:0];
	// top index bit picks the channel, channel 0 first
	assign rd_chan  = rd_index[7];

	always_ff @(posedge mai) begin
		if (wr.we) begin
			mem0[wr_entry] <= wr.byte0;
			mem1[wr_entry] <= wr.byte1;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge mai) begin
		if (rd_chan) begin
			rd_byte <= mem1[rd_entry];
		end else begin
			rd_byte <= mem0[rd_entry];
		end
	end

endmodule

`default_nettype wire

//--- logic/probe_pkg.sv
`default_nettype none

package probe_pkg;

	// host port and sampler widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;
	localparam int DIV_W  = 24;
	localparam int SEL_W  = 8;

	// register offsets on the host port
	localparam logic [ADDR_W-1:0] REG_PIN_SEL0  = 8'h00;
	localparam logic [ADDR_W-1:0] REG_DATA      = 8'h01;
	localparam logic [ADDR_W-1:0] REG_IDX_RESET = 8'h02;
	localparam logic [ADDR_W-1:0] REG_ARM       = 8'h03;
	localparam logic [ADDR_W-1:0] REG_PIN_SEL1  = 8'h04;
	localparam logic [ADDR_W-1:0] REG_DIV0      = 8'h05;
	localparam logic [ADDR_W-1:0] REG_DIV1      = 8'h08;
	localparam logic [ADDR_W-1:0] REG_DIV2      = 8'h09;
	localparam logic [ADDR_W-1:0] REG_READY     = 8'h0E;

	// one host access held stable while req is up
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              wr;
		logic [DATA_W-1:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [SEL_W-1:0] pin_sel0;
		logic [SEL_W-1:0] pin_sel1;
		logic [DIV_W-1:0] divider;
	} probe_cfg_t;

	// both channels are written together at one byte index
	typedef struct packed {
		logic       we;
		logic [7:0] addr;
		logic [7:0] byte0;
		logic [7:0] byte1;
	} cap_wr_t;

endpackage

`default_nettype wire
